// ==== common/bus_pkg.sv ====
/*
 * bus package
 * Wishbone address and memory line types for the fetch frontend
 */
package bus_pkg;

    // byte address on the bus
    typedef logic [31:0] addr_t;

    // one memory line, 16 bytes
    typedef logic [127:0] line_t;

    // bytes per line, also the address step between lines
    localparam int unsigned LINE_BYTES = 16;

endpackage : bus_pkg

// ==== common/fetch_pkg.sv ====
/*
 * fetch package
 * parcel, byte count, line offset and read size types of the aligner
 */
package fetch_pkg;

    // parcel output, 16-bit reads use the low half only
    typedef logic [31:0] parcel_t;

    // halfword offset inside a line
    typedef logic [2:0] offset_t;

    // bytes held in the two-line buffer, 0 to 32
    typedef logic [5:0] byte_cnt_t;

    // size of one parcel read
    typedef enum logic {
        SIZE_16 = 1'b0,
        SIZE_32 = 1'b1
    } rsize_e;

endpackage : fetch_pkg

// ==== common/line_push_if.sv ====
/*
 * line push interface
 * fetcher to FIFO, carries lines plus the redirect flush and its start offset
 */
`timescale 1ns/1ns

interface line_push_if;

    logic               push;
    bus_pkg::line_t     line;
    logic               full;
    logic               flush;     // single cycle, wins over push
    fetch_pkg::offset_t start_off;

    modport producer (
        output push,
        output line,
        output flush,
        output start_off,
        input  full
    );

    modport consumer (
        input  push,
        input  line,
        input  flush,
        input  start_off,
        output full
    );

endinterface : line_push_if

// ==== common/line_pop_if.sv ====
/*
 * line pop interface
 * FIFO to aligner, first-word-fall-through lines and the forwarded flush
 */
`timescale 1ns/1ns

interface line_pop_if;

    bus_pkg::line_t     line;      // valid while empty is low
    logic               empty;
    logic               pop;
    logic               flush;
    fetch_pkg::offset_t start_off;

    modport producer (
        output line,
        output empty,
        output flush,
        output start_off,
        input  pop
    );

    modport consumer (
        input  line,
        input  empty,
        input  flush,
        input  start_off,
        output pop
    );

endinterface : line_pop_if

// ==== hw/line_fetcher.sv ====
/*
 * line fetcher
 * Wishbone classic read master for sequential lines, restarts on redirect
 */
`timescale 1ns/1ns

module line_fetcher #(
    parameter bus_pkg::addr_t RESET_ADDR = '0    // line aligned
) (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           redirect_i,
    input  bus_pkg::addr_t redirect_addr_i,
    output bus_pkg::addr_t wb_adr_o,
    input  bus_pkg::line_t wb_dat_i,
    output logic           wb_cyc_o,
    output logic           wb_stb_o,
    input  logic           wb_ack_i,
    line_push_if.producer  push_o
);

    typedef enum logic [1:0] {IDLE, BUS, PUSH, DROP} state_e;

    localparam bus_pkg::addr_t LINE_MASK = bus_pkg::addr_t'(bus_pkg::LINE_BYTES - 1);

    state_e         state_q, state_d;
    bus_pkg::addr_t next_addr_q;   // address of the next line to request
    bus_pkg::addr_t adr_q;         // address of the open bus cycle
    bus_pkg::line_t line_q;
    logic           start;

    // only request when the FIFO has room for this line
    assign start = (state_q == IDLE) && !redirect_i && !push_o.full;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (start) state_d = BUS;
            BUS: begin
                if (wb_ack_i) begin
                    state_d = redirect_i ? IDLE : PUSH;
                end else if (redirect_i) begin
                    state_d = DROP;     // let the slave finish, data is stale
                end
            end
            PUSH: state_d = IDLE;       // also the idle gap on the bus
            DROP: if (wb_ack_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= IDLE;
            next_addr_q <= RESET_ADDR;
            adr_q       <= '0;
        end else begin
            state_q <= state_d;
            if (redirect_i) begin
                next_addr_q <= redirect_addr_i & ~LINE_MASK;
            end else if (state_q == BUS && wb_ack_i) begin
                next_addr_q <= next_addr_q + bus_pkg::LINE_BYTES;
            end
            if (start) begin
                adr_q <= next_addr_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == BUS && wb_ack_i) line_q <= wb_dat_i;
    end

    assign wb_cyc_o = (state_q == BUS) || (state_q == DROP);
    assign wb_stb_o = wb_cyc_o;
    assign wb_adr_o = adr_q;

    assign push_o.push      = (state_q == PUSH);
    assign push_o.line      = line_q;
    assign push_o.flush     = redirect_i;
    assign push_o.start_off = fetch_pkg::offset_t'(redirect_addr_i[3:1]);   // halfword in line

    // the slave may sample the address on any cycle of the request
    a_adr_stable: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (wb_stb_o && !wb_ack_i) |=> $stable(wb_adr_o)
    );

endmodule : line_fetcher

// ==== hw/line_fifo.sv ====
/*
 * line FIFO
 * first-word-fall-through buffer of memory lines with flush
 */
`timescale 1ns/1ns

module line_fifo #(
    parameter int unsigned FIFO_DEPTH = 4    // power of two
) (
    input  logic          clk_i,
    input  logic          rstn_i,
    line_push_if.consumer push_i,
    line_pop_if.producer  pop_o
);

    localparam int unsigned IW = $clog2(FIFO_DEPTH);

    bus_pkg::line_t mem_q [FIFO_DEPTH];
    logic [IW:0]    wr_ptr_q;    // extra msb tells full from empty
    logic [IW:0]    rd_ptr_q;
    logic           full;
    logic           empty;
    logic           do_push;
    logic           do_pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[IW] != rd_ptr_q[IW]) &&
                   (wr_ptr_q[IW-1:0] == rd_ptr_q[IW-1:0]);

    // flush wins over both sides
    assign do_push = push_i.push && !full && !push_i.flush;
    assign do_pop  = pop_o.pop && !empty && !push_i.flush;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (push_i.flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) mem_q[wr_ptr_q[IW-1:0]] <= push_i.line;
    end

    assign push_i.full = full;

    assign pop_o.line      = mem_q[rd_ptr_q[IW-1:0]];   // head shows without a pop
    assign pop_o.empty     = empty;
    assign pop_o.flush     = push_i.flush;               // same cycle to the aligner
    assign pop_o.start_off = push_i.start_off;

    // fetcher credit keeps pushes off a full FIFO
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        push_i.push |-> !full
    );

    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        pop_o.pop |-> !empty
    );

endmodule : line_fifo

// ==== hw/parcel_aligner/parcel_aligner.sv ====
/*
 * parcel aligner
 * 32-byte shift buffer that hands out 16- or 32-bit parcels across line edges
 */
`timescale 1ns/1ns

module parcel_aligner (
    input  logic               clk_i,
    input  logic               rstn_i,
    line_pop_if.consumer       pop_i,
    input  logic               re_i,
    input  logic               rsize_i,
    output fetch_pkg::parcel_t rdata_o,
    output logic               empty_o,
    output logic               half_only_o
);

    localparam fetch_pkg::byte_cnt_t LINE_CNT = fetch_pkg::byte_cnt_t'(bus_pkg::LINE_BYTES);

    fetch_pkg::rsize_e    rsize;
    fetch_pkg::byte_cnt_t cnt_q;      // valid bytes, oldest at bit 0
    fetch_pkg::byte_cnt_t cnt_d;
    fetch_pkg::byte_cnt_t cnt_rd;     // count after the read
    fetch_pkg::byte_cnt_t rd_bytes;
    fetch_pkg::offset_t   skip_q;     // halfwords to drop from the next line
    logic [255:0]         buf_q;
    logic [255:0]         buf_d;
    logic [255:0]         kept;
    logic [255:0]         ins;
    logic                 rd_fire;
    logic                 pop;

    assign rsize    = fetch_pkg::rsize_e'(rsize_i);
    assign rd_bytes = (rsize == fetch_pkg::SIZE_32) ? 6'd4 : 6'd2;
    assign rd_fire  = re_i && !empty_o && !pop_i.flush;

    // room for a whole line once the second slot is free
    assign pop = !pop_i.empty && !pop_i.flush && (cnt_q <= LINE_CNT);
    assign pop_i.pop = pop;

    // new line with the redirect offset already stripped
    assign ins = 256'(pop_i.line) >> {skip_q, 4'b0000};

    always_comb begin
        cnt_rd = rd_fire ? cnt_q - rd_bytes : cnt_q;
        kept   = rd_fire ? buf_q >> {rd_bytes, 3'b000} : buf_q;
        kept   = kept & ~({256{1'b1}} << {cnt_rd, 3'b000});   // clear stale upper bytes
        buf_d  = kept;
        cnt_d  = cnt_rd;
        if (pop) begin
            buf_d = kept | (ins << {cnt_rd, 3'b000});         // append behind the old bytes
            cnt_d = cnt_rd + (LINE_CNT - {skip_q, 1'b0});
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q  <= '0;
            skip_q <= '0;
        end else if (pop_i.flush) begin
            cnt_q  <= '0;
            skip_q <= pop_i.start_off;   // applies to the first line after redirect
        end else begin
            cnt_q <= cnt_d;
            if (pop) skip_q <= '0;
        end
    end

    always_ff @(posedge clk_i) begin
        buf_q <= buf_d;
    end

    // no read latency, the oldest bytes are always on the output
    assign rdata_o     = buf_q[31:0];
    assign empty_o     = (cnt_q < 6'd2);
    assign half_only_o = (cnt_q == 6'd2) || (cnt_q == 6'd3);

    a_no_read_empty: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        re_i |-> !empty_o
    );

    // a wide read needs both halves present
    a_no_wide_half: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (re_i && rsize == fetch_pkg::SIZE_32) |-> !half_only_o
    );

endmodule : parcel_aligner

// ==== hw/fetch_frontend.sv ====
/*
 * fetch frontend top level
 * Wishbone line fetcher, line FIFO and parcel aligner
 */
`timescale 1ns/1ns

module fetch_frontend #(
    parameter int unsigned    FIFO_DEPTH = 4,
    parameter bus_pkg::addr_t RESET_ADDR = '0
) (
    input  logic               clk_i,
    input  logic               rstn_i,

    input  logic               redirect_i,
    input  bus_pkg::addr_t     redirect_addr_i,

    output bus_pkg::addr_t     wb_adr_o,
    input  bus_pkg::line_t     wb_dat_i,
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    input  logic               wb_ack_i,

    input  logic               re_i,
    input  logic               rsize_i,    // 1 = 32 bit
    output fetch_pkg::parcel_t rdata_o,
    output logic               empty_o,
    output logic               half_only_o
);

    line_push_if push_if ();
    line_pop_if  pop_if ();

    line_fetcher #(
        .RESET_ADDR (RESET_ADDR)
    ) u_fetcher (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .redirect_i      (redirect_i),
        .redirect_addr_i (redirect_addr_i),
        .wb_adr_o        (wb_adr_o),
        .wb_dat_i        (wb_dat_i),
        .wb_cyc_o        (wb_cyc_o),
        .wb_stb_o        (wb_stb_o),
        .wb_ack_i        (wb_ack_i),
        .push_o          (push_if.producer)
    );

    line_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .push_i (push_if.consumer),
        .pop_o  (pop_if.producer)
    );

    parcel_aligner u_aligner (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .pop_i       (pop_if.consumer),
        .re_i        (re_i),
        .rsize_i     (rsize_i),
        .rdata_o     (rdata_o),
        .empty_o     (empty_o),
        .half_only_o (half_only_o)
    );

endmodule : fetch_frontend

// ==== verification/wb_mem_model.sv ====
/*
 * Wishbone memory model
 * read-only classic slave with a random ack delay, data computed from the address
 */
`timescale 1ns/1ns

module wb_mem_model (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  bus_pkg::addr_t adr_i,
    input  logic           cyc_i,
    input  logic           stb_i,
    output bus_pkg::line_t dat_o,
    output logic           ack_o
);

    logic [1:0] wait_q;    // cycles left before ack
    logic       busy_q;    // request seen, still waiting
    logic [1:0] delay;

    // byte at address a is the low 8 bits of a * 7 + 3
    function automatic bus_pkg::line_t line_at(input bus_pkg::addr_t a);
        bus_pkg::line_t l;
        for (int i = 0; i < bus_pkg::LINE_BYTES; i++) begin
            l[8*i +: 8] = 8'((a + i) * 7 + 3);
        end
        return l;
    endfunction

    always @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ack_o  <= 1'b0;
            busy_q <= 1'b0;
            wait_q <= '0;
            dat_o  <= '0;
        end else begin
            ack_o <= 1'b0;    // ack is a single cycle pulse
            if (cyc_i && stb_i && !ack_o) begin
                delay = busy_q ? wait_q : 2'($urandom_range(0, 3));
                if (delay == 2'd0) begin
                    ack_o  <= 1'b1;
                    dat_o  <= line_at(adr_i);
                    busy_q <= 1'b0;
                end else begin
                    wait_q <= delay - 2'd1;
                    busy_q <= 1'b1;
                end
            end
        end
    end

endmodule : wb_mem_model

// ==== verification/tb_fetch_frontend.sv ====
/*
 * fetch frontend testbench
 * random reads and redirects checked against a byte-stream model of memory
 */
`timescale 1ns/1ns

module tb_fetch_frontend;

    localparam bus_pkg::addr_t RESET_ADDR = 32'h0000_0100;
    localparam int NUM_READS    = 3000;
    localparam int STALL_AT     = 1500;     // reads done before the long stall
    localparam int STALL_CYCLES = 200;
    localparam int TIMEOUT      = 20000;    // about twice the longest expected run

    logic               clk = 1'b0;
    logic               rstn;
    logic               redirect;
    bus_pkg::addr_t     redirect_addr;
    bus_pkg::addr_t     wb_adr;
    bus_pkg::line_t     wb_dat;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_ack;
    logic               re;
    logic               rsize;
    fetch_pkg::parcel_t rdata;
    logic               empty;
    logic               half_only;

    bus_pkg::addr_t ptr;               // oldest byte not yet read
    logic           after_redirect;
    logic           stalled = 1'b0;
    int             reads = 0;
    int             crossings = 0;     // wide reads from byte 14 of a line
    int             odd_redirects = 0;
    int             cycles = 0;

    always #5 clk = ~clk;

    fetch_frontend #(
        .FIFO_DEPTH (4),
        .RESET_ADDR (RESET_ADDR)
    ) dut (
        .clk_i (clk), .rstn_i (rstn),
        .redirect_i (redirect), .redirect_addr_i (redirect_addr),
        .wb_adr_o (wb_adr), .wb_dat_i (wb_dat), .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb), .wb_ack_i (wb_ack),
        .re_i (re), .rsize_i (rsize), .rdata_o (rdata),
        .empty_o (empty), .half_only_o (half_only)
    );

    wb_mem_model u_mem (
        .clk_i (clk), .rstn_i (rstn), .adr_i (wb_adr), .cyc_i (wb_cyc),
        .stb_i (wb_stb), .dat_o (wb_dat), .ack_o (wb_ack)
    );

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "stopped at %0t", $time);
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("timeout, the test did not finish within %0d cycles", TIMEOUT);
            abort_run();
        end
    end

    function automatic logic [31:0] expected_parcel(input bus_pkg::addr_t a);
        logic [31:0] p;
        for (int i = 0; i < 4; i++) begin
            p[8*i +: 8] = 8'((a + i) * 7 + 3);    // memory fill rule
        end
        return p;
    endfunction

    task automatic check_reset_state(input string name);
        check_eq({name, "_cyc"}, 32'd0, 32'(wb_cyc));
        check_eq({name, "_stb"}, 32'd0, 32'(wb_stb));
        check_eq({name, "_empty"}, 32'd1, 32'(empty));
    endtask

    // outputs are stable at the falling edge
    task automatic check_outputs();
        logic [31:0] exp;
        exp = expected_parcel(ptr);
        if (after_redirect) check_eq("redirect_empty", 32'd1, 32'(empty));
        after_redirect = 1'b0;
        if (half_only) check_eq("half_only_not_empty", 32'd0, 32'(empty));
        if (!empty) begin
            check_eq("parcel_low16", {16'h0, exp[15:0]}, {16'h0, rdata[15:0]});
            if (!half_only) check_eq("parcel_32", exp, rdata);
        end
    endtask

    task automatic stall_consumer();
        for (int i = 0; i < STALL_CYCLES; i++) begin
            @(negedge clk);
            check_outputs();
            if (i >= STALL_CYCLES / 2) check_eq("stall_cyc_low", 32'd0, 32'(wb_cyc));
        end
    endtask

    initial begin
        bus_pkg::addr_t tgt;
        int unsigned    act;
        logic           wide;
        logic           covered;
        void'($urandom(85));
        rstn = 1'b0;
        redirect = 1'b0;
        redirect_addr = '0;
        re = 1'b0;
        rsize = 1'b0;
        ptr = RESET_ADDR;
        after_redirect = 1'b0;
        @(negedge clk);
        check_reset_state("reset_hold");
        @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_reset_state("reset_release");

        // one action per step, inputs idle again before the next decision
        while (reads < NUM_READS) begin
            @(negedge clk);
            check_outputs();
            act = $urandom_range(0, 63);
            if (reads == STALL_AT && !stalled) begin
                stall_consumer();
                stalled = 1'b1;
            end else if (act == 0) begin
                tgt = $urandom & 32'h0000_fffe;    // halfword aligned
                @(posedge clk);
                redirect <= 1'b1;
                redirect_addr <= tgt;
                @(posedge clk);
                redirect <= 1'b0;
                ptr = tgt;
                after_redirect = 1'b1;
                if (tgt[1]) odd_redirects++;
            end else if (!empty && act < 48) begin
                wide = ($urandom_range(0, 1) == 1) && !half_only;
                @(posedge clk);
                re <= 1'b1;
                rsize <= wide;
                @(posedge clk);
                re <= 1'b0;
                if (wide && ptr[3:0] == 4'd14) crossings++;
                ptr = ptr + (wide ? 4 : 2);
                reads++;
            end
        end

        covered = (crossings > 0) && (odd_redirects > 0);
        assert (covered) else begin
            $display("no wide read crossed a line or no redirect hit an odd halfword");
        end
        if (covered) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule : tb_fetch_frontend

// ==== tb.f ====
common/bus_pkg.sv
common/fetch_pkg.sv
common/line_push_if.sv
common/line_pop_if.sv
hw/line_fetcher.sv
hw/line_fifo.sv
hw/parcel_aligner/parcel_aligner.sv
hw/fetch_frontend.sv
verification/wb_mem_model.sv
verification/tb_fetch_frontend.sv
